//--- rtl/rooth_params.svh
// rooth execute path widths, instruction encodings and divider step count
`ifndef ROOTH_PARAMS_SVH
`define ROOTH_PARAMS_SVH

// ---------------------------------------------------------------------
// datapath and register file
// ---------------------------------------------------------------------
`define ROOTH_XLEN          32
`define ROOTH_REG_ADDR_W    5
`define ROOTH_NUM_REGS      32

// ---------------------------------------------------------------------
// opcodes and funct7 codes
// ---------------------------------------------------------------------
`define ROOTH_OPC_OP        7'b0110011
`define ROOTH_OPC_OP_IMM    7'b0010011

`define ROOTH_FUNCT7_BASE   7'b0000000
`define ROOTH_FUNCT7_ALT    7'b0100000
`define ROOTH_FUNCT7_MULDIV 7'b0000001

// one quotient bit per step
`define ROOTH_DIV_STEPS     32

`endif

//--- rtl/rooth_pkg.sv
// rooth shared types: execution unit operations and the instruction word views
`default_nettype none

`include "rooth_params.svh"

package rooth_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // same order as funct3[1:0]
    typedef enum logic [1:0] {
        DIV_DIV  = 2'b00,
        DIV_DIVU = 2'b01,
        DIV_REM  = 2'b10,
        DIV_REMU = 2'b11
    } div_op_e;

    typedef struct packed {
        logic [6:0]                   funct7;
        logic [`ROOTH_REG_ADDR_W-1:0] rs2;
        logic [`ROOTH_REG_ADDR_W-1:0] rs1;
        logic [2:0]                   funct3;
        logic [`ROOTH_REG_ADDR_W-1:0] rd;
        logic [6:0]                   opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]                  imm12;
        logic [`ROOTH_REG_ADDR_W-1:0] rs1;
        logic [2:0]                   funct3;
        logic [`ROOTH_REG_ADDR_W-1:0] rd;
        logic [6:0]                   opcode;
    } i_type_t;

    // opcode picks the valid view
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } rv_inst_u;

endpackage

`default_nettype wire

//--- rtl/ex_req_if.sv
// issued operation from the issue stage to the ALU and the divider
`timescale 1ns/1ps
`default_nettype none

`include "rooth_params.svh"

interface ex_req_if;

    logic                    alu_start;
    logic                    div_start;
    rooth_pkg::alu_op_e      alu_op;
    rooth_pkg::div_op_e      div_op;
    logic [`ROOTH_XLEN-1:0]  src1;
    logic [`ROOTH_XLEN-1:0]  src2;

    modport issue (
        output alu_start, div_start, alu_op, div_op, src1, src2
    );

    modport alu (
        input alu_start, alu_op, src1, src2
    );

    modport div (
        input div_start, div_op, src1, src2
    );

endinterface

`default_nettype wire

//--- rtl/issue_ctrl.sv
// issue stage: decodes one instruction, reads operands and starts a unit
`timescale 1ns/1ps
`default_nettype none

`include "rooth_params.svh"

module issue_ctrl (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         inst_valid_i,
    input  rooth_pkg::rv_inst_u          inst_i,
    output logic [`ROOTH_REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`ROOTH_REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [`ROOTH_XLEN-1:0]       rs1_data_i,
    input  logic [`ROOTH_XLEN-1:0]       rs2_data_i,
    input  logic                         retire_i,
    output logic                         busy_o,
    output logic [`ROOTH_REG_ADDR_W-1:0] rd_o,
    ex_req_if.issue                      req
);

    logic                         busy_q;
    logic [`ROOTH_REG_ADDR_W-1:0] rd_q;
    logic                         dec_ok;
    logic                         dec_div;
    rooth_pkg::alu_op_e           dec_alu_op;
    logic [`ROOTH_XLEN-1:0]       dec_src2;
    logic                         accept;

    // funct3 to ALU op for the plain (base funct7) encodings
    function automatic rooth_pkg::alu_op_e base_op(input logic [2:0] f3);
        case (f3)
            3'd0:    base_op = rooth_pkg::ALU_ADD;
            3'd1:    base_op = rooth_pkg::ALU_SLL;
            3'd2:    base_op = rooth_pkg::ALU_SLT;
            3'd3:    base_op = rooth_pkg::ALU_SLTU;
            3'd4:    base_op = rooth_pkg::ALU_XOR;
            3'd5:    base_op = rooth_pkg::ALU_SRL;
            3'd6:    base_op = rooth_pkg::ALU_OR;
            default: base_op = rooth_pkg::ALU_AND;
        endcase
    endfunction

    assign rs1_addr_o = inst_i.r.rs1;
    assign rs2_addr_o = inst_i.r.rs2;

    // ---------------------------------------------------------------------
    // decode
    // ---------------------------------------------------------------------
    always_comb begin
        dec_ok     = 1'b0;
        dec_div    = 1'b0;
        dec_alu_op = base_op(inst_i.r.funct3);
        dec_src2   = rs2_data_i;
        if (inst_i.r.opcode == `ROOTH_OPC_OP) begin
            case (inst_i.r.funct7)
                `ROOTH_FUNCT7_BASE: dec_ok = 1'b1;
                `ROOTH_FUNCT7_ALT: begin
                    dec_ok     = (inst_i.r.funct3 == 3'd0) || (inst_i.r.funct3 == 3'd5);
                    dec_alu_op = (inst_i.r.funct3 == 3'd0) ? rooth_pkg::ALU_SUB
                                                           : rooth_pkg::ALU_SRA;
                end
                `ROOTH_FUNCT7_MULDIV: begin
                    // multiplies are not supported
                    dec_ok  = inst_i.r.funct3[2];
                    dec_div = 1'b1;
                end
                default: dec_ok = 1'b0;
            endcase
        end else if (inst_i.i.opcode == `ROOTH_OPC_OP_IMM) begin
            dec_src2 = {{(`ROOTH_XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
            case (inst_i.i.funct3)
                3'd1: dec_ok = (inst_i.r.funct7 == `ROOTH_FUNCT7_BASE);
                3'd5: begin
                    dec_ok = (inst_i.r.funct7 == `ROOTH_FUNCT7_BASE) ||
                             (inst_i.r.funct7 == `ROOTH_FUNCT7_ALT);
                    if (inst_i.r.funct7 == `ROOTH_FUNCT7_ALT) begin
                        dec_alu_op = rooth_pkg::ALU_SRA;
                    end
                end
                default: dec_ok = 1'b1;
            endcase
            // shift amount only
            if (inst_i.i.funct3[1:0] == 2'b01) begin
                dec_src2 = {{(`ROOTH_XLEN-5){1'b0}}, inst_i.i.imm12[4:0]};
            end
        end
    end

    assign accept = inst_valid_i && !busy_q && dec_ok;

    // ---------------------------------------------------------------------
    // issue and busy tracking
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q        <= 1'b0;
            req.alu_start <= 1'b0;
            req.div_start <= 1'b0;
        end else begin
            req.alu_start <= accept && !dec_div;
            req.div_start <= accept && dec_div;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (retire_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // operands held until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            req.src1   <= rs1_data_i;
            req.src2   <= dec_src2;
            req.alu_op <= dec_alu_op;
            req.div_op <= rooth_pkg::div_op_e'(inst_i.r.funct3[1:0]);
            rd_q       <= inst_i.r.rd;
        end
    end

    assign busy_o = busy_q;
    assign rd_o   = rd_q;

endmodule

`default_nettype wire

//--- rtl/alu_unit.sv
// single-cycle RV32I integer ALU with a registered result
`timescale 1ns/1ps
`default_nettype none

`include "rooth_params.svh"

module alu_unit (
    input  logic                   clk,
    input  logic                   rst_n_i,
    ex_req_if.alu                  req,
    output logic                   done_o,
    output logic [`ROOTH_XLEN-1:0] res_o
);

    logic [`ROOTH_XLEN-1:0] a;
    logic [`ROOTH_XLEN-1:0] b;
    logic [4:0]             shamt;
    logic [`ROOTH_XLEN-1:0] res;

    assign a     = req.src1;
    assign b     = req.src2;
    assign shamt = req.src2[4:0];

    always_comb begin
        case (req.alu_op)
            rooth_pkg::ALU_ADD:  res = a + b;
            rooth_pkg::ALU_SUB:  res = a - b;
            rooth_pkg::ALU_SLL:  res = a << shamt;
            rooth_pkg::ALU_SLT:  res = {{(`ROOTH_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rooth_pkg::ALU_SLTU: res = {{(`ROOTH_XLEN-1){1'b0}}, a < b};
            rooth_pkg::ALU_XOR:  res = a ^ b;
            rooth_pkg::ALU_SRL:  res = a >> shamt;
            rooth_pkg::ALU_SRA:  res = $signed(a) >>> shamt;
            rooth_pkg::ALU_OR:   res = a | b;
            rooth_pkg::ALU_AND:  res = a & b;
            default:             res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= req.alu_start;
        end
    end

    always_ff @(posedge clk) begin
        if (req.alu_start) begin
            res_o <= res;
        end
    end

endmodule

`default_nettype wire

//--- rtl/div_unit.sv
// iterative restoring divider for DIV, DIVU, REM and REMU
`timescale 1ns/1ps
`default_nettype none

`include "rooth_params.svh"

module div_unit (
    input  logic                   clk,
    input  logic                   rst_n_i,
    ex_req_if.div                  req,
    output logic                   done_o,
    output logic [`ROOTH_XLEN-1:0] res_o
);

    localparam int CNT_W = $clog2(`ROOTH_DIV_STEPS);

    logic                   busy_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [`ROOTH_XLEN-1:0] quot_q;
    logic [`ROOTH_XLEN-1:0] rem_q;
    logic [`ROOTH_XLEN-1:0] dsr_q;
    logic                   neg_q_q;
    logic                   neg_r_q;
    logic                   sel_rem_q;

    logic                   is_signed;
    logic                   sign_a;
    logic                   sign_b;
    logic [`ROOTH_XLEN:0]   shifted;
    logic [`ROOTH_XLEN:0]   diff;

    assign is_signed = !req.div_op[0];
    assign sign_a    = is_signed && req.src1[`ROOTH_XLEN-1];
    assign sign_b    = is_signed && req.src2[`ROOTH_XLEN-1];

    // one restoring step
    assign shifted = {rem_q, quot_q[`ROOTH_XLEN-1]};
    assign diff    = shifted - {1'b0, dsr_q};

    // ---------------------------------------------------------------------
    // control
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= busy_q && (cnt_q == CNT_W'(`ROOTH_DIV_STEPS - 1));
            if (req.div_start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(`ROOTH_DIV_STEPS - 1)) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // ---------------------------------------------------------------------
    // datapath on magnitudes
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (req.div_start) begin
            quot_q    <= sign_a ? -req.src1 : req.src1;
            dsr_q     <= sign_b ? -req.src2 : req.src2;
            rem_q     <= '0;
            // a zero divisor leaves the all-ones quotient unsigned
            neg_q_q   <= (sign_a ^ sign_b) && (req.src2 != '0);
            neg_r_q   <= sign_a;
            sel_rem_q <= req.div_op[1];
        end else if (busy_q) begin
            if (!diff[`ROOTH_XLEN]) begin
                rem_q  <= diff[`ROOTH_XLEN-1:0];
                quot_q <= {quot_q[`ROOTH_XLEN-2:0], 1'b1};
            end else begin
                rem_q  <= shifted[`ROOTH_XLEN-1:0];
                quot_q <= {quot_q[`ROOTH_XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fix-up; most negative / -1 wraps back to the dividend with rem 0
    always_comb begin
        if (sel_rem_q) begin
            res_o = neg_r_q ? -rem_q : rem_q;
        end else begin
            res_o = neg_q_q ? -quot_q : quot_q;
        end
    end

endmodule

`default_nettype wire

//--- rtl/wb_ctrl.sv
// writeback: picks the finished unit result, writes it and reports retirement
`timescale 1ns/1ps
`default_nettype none

`include "rooth_params.svh"

module wb_ctrl (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         alu_done_i,
    input  logic [`ROOTH_XLEN-1:0]       alu_res_i,
    input  logic                         div_done_i,
    input  logic [`ROOTH_XLEN-1:0]       div_res_i,
    input  logic [`ROOTH_REG_ADDR_W-1:0] rd_i,
    output logic                         wr_en_o,
    output logic [`ROOTH_REG_ADDR_W-1:0] wr_addr_o,
    output logic [`ROOTH_XLEN-1:0]       wr_data_o,
    output logic                         retire_o,
    output logic [`ROOTH_REG_ADDR_W-1:0] retire_rd_o,
    output logic [`ROOTH_XLEN-1:0]       retire_data_o
);

    // only one unit runs at a time
    assign wr_en_o   = alu_done_i || div_done_i;
    assign wr_addr_o = rd_i;
    assign wr_data_o = alu_done_i ? alu_res_i : div_res_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_o <= 1'b0;
        end else begin
            retire_o <= wr_en_o;
        end
    end

    // x0 still reports its computed value
    always_ff @(posedge clk) begin
        if (wr_en_o) begin
            retire_rd_o   <= wr_addr_o;
            retire_data_o <= wr_data_o;
        end
    end

endmodule

`default_nettype wire

//--- rtl/regs_file.sv
// 32 x 32 integer register file with two read ports and a debug access port
`timescale 1ns/1ps
`default_nettype none

`include "rooth_params.svh"

module regs_file (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         wr_en_i,
    input  logic [`ROOTH_REG_ADDR_W-1:0] wr_addr_i,
    input  logic [`ROOTH_XLEN-1:0]       wr_data_i,
    input  logic [`ROOTH_REG_ADDR_W-1:0] rs1_addr_i,
    output logic [`ROOTH_XLEN-1:0]       rs1_data_o,
    input  logic [`ROOTH_REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`ROOTH_XLEN-1:0]       rs2_data_o,
    input  logic                         jtag_we_i,
    input  logic [`ROOTH_REG_ADDR_W-1:0] jtag_addr_i,
    input  logic [`ROOTH_XLEN-1:0]       jtag_data_i,
    output logic [`ROOTH_XLEN-1:0]       jtag_data_o
);

    // x0 has no storage
    logic [`ROOTH_XLEN-1:0] regs_q [1:`ROOTH_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `ROOTH_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end else if (jtag_we_i && (jtag_addr_i != '0)) begin
            regs_q[jtag_addr_i] <= jtag_data_i;
        end
    end

    assign rs1_data_o  = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o  = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];
    assign jtag_data_o = (jtag_addr_i == '0) ? '0 : regs_q[jtag_addr_i];

endmodule

`default_nettype wire

//--- rtl/rooth_top.sv
// rooth execute core top: issue, ALU, divider, writeback and register file
`timescale 1ns/1ps
`default_nettype none

`include "rooth_params.svh"

module rooth_top (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         inst_valid_i,
    input  logic [31:0]                  inst_i,
    output logic                         busy_o,
    output logic                         retire_o,
    output logic [`ROOTH_REG_ADDR_W-1:0] retire_rd_o,
    output logic [`ROOTH_XLEN-1:0]       retire_data_o,
    input  logic                         jtag_we_i,
    input  logic [`ROOTH_REG_ADDR_W-1:0] jtag_addr_i,
    input  logic [`ROOTH_XLEN-1:0]       jtag_data_i,
    output logic [`ROOTH_XLEN-1:0]       jtag_data_o
);

    ex_req_if ex_req ();

    logic [`ROOTH_REG_ADDR_W-1:0] rs1_addr;
    logic [`ROOTH_REG_ADDR_W-1:0] rs2_addr;
    logic [`ROOTH_XLEN-1:0]       rs1_data;
    logic [`ROOTH_XLEN-1:0]       rs2_data;
    logic [`ROOTH_REG_ADDR_W-1:0] rd;
    logic                         alu_done;
    logic [`ROOTH_XLEN-1:0]       alu_res;
    logic                         div_done;
    logic [`ROOTH_XLEN-1:0]       div_res;
    logic                         wr_en;
    logic [`ROOTH_REG_ADDR_W-1:0] wr_addr;
    logic [`ROOTH_XLEN-1:0]       wr_data;

    issue_ctrl u_issue_ctrl_0 (
        .clk          ( clk          ),
        .rst_n_i      ( rst_n_i      ),
        .inst_valid_i ( inst_valid_i ),
        .inst_i       ( inst_i       ),
        .rs1_addr_o   ( rs1_addr     ),
        .rs2_addr_o   ( rs2_addr     ),
        .rs1_data_i   ( rs1_data     ),
        .rs2_data_i   ( rs2_data     ),
        .retire_i     ( wr_en        ),
        .busy_o       ( busy_o       ),
        .rd_o         ( rd           ),
        .req          ( ex_req.issue )
    );

    alu_unit u_alu_unit_0 (
        .clk     ( clk        ),
        .rst_n_i ( rst_n_i    ),
        .req     ( ex_req.alu ),
        .done_o  ( alu_done   ),
        .res_o   ( alu_res    )
    );

    div_unit u_div_unit_0 (
        .clk     ( clk        ),
        .rst_n_i ( rst_n_i    ),
        .req     ( ex_req.div ),
        .done_o  ( div_done   ),
        .res_o   ( div_res    )
    );

    wb_ctrl u_wb_ctrl_0 (
        .clk           ( clk           ),
        .rst_n_i       ( rst_n_i       ),
        .alu_done_i    ( alu_done      ),
        .alu_res_i     ( alu_res       ),
        .div_done_i    ( div_done      ),
        .div_res_i     ( div_res       ),
        .rd_i          ( rd            ),
        .wr_en_o       ( wr_en         ),
        .wr_addr_o     ( wr_addr       ),
        .wr_data_o     ( wr_data       ),
        .retire_o      ( retire_o      ),
        .retire_rd_o   ( retire_rd_o   ),
        .retire_data_o ( retire_data_o )
    );

    regs_file u_regs_file_0 (
        .clk         ( clk         ),
        .rst_n_i     ( rst_n_i     ),
        .wr_en_i     ( wr_en       ),
        .wr_addr_i   ( wr_addr     ),
        .wr_data_i   ( wr_data     ),
        .rs1_addr_i  ( rs1_addr    ),
        .rs1_data_o  ( rs1_data    ),
        .rs2_addr_i  ( rs2_addr    ),
        .rs2_data_o  ( rs2_data    ),
        .jtag_we_i   ( jtag_we_i   ),
        .jtag_addr_i ( jtag_addr_i ),
        .jtag_data_i ( jtag_data_i ),
        .jtag_data_o ( jtag_data_o )
    );

endmodule

`default_nettype wire

//--- verif/tb_rooth.sv
// directed testbench for the rooth execute core: ALU, divider, busy and debug port
`timescale 1ns/1ps
`default_nettype none

module tb_rooth;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        busy;
    logic        retire;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        jtag_we;
    logic [4:0]  jtag_addr;
    logic [31:0] jtag_wdata;
    logic [31:0] jtag_rdata;
    logic [31:0] lfsr_state;

    rooth_top uut (
        .clk           ( clk         ),
        .rst_n_i       ( rst_n       ),
        .inst_valid_i  ( inst_valid  ),
        .inst_i        ( inst        ),
        .busy_o        ( busy        ),
        .retire_o      ( retire      ),
        .retire_rd_o   ( retire_rd   ),
        .retire_data_o ( retire_data ),
        .jtag_we_i     ( jtag_we     ),
        .jtag_addr_i   ( jtag_addr   ),
        .jtag_data_i   ( jtag_wdata  ),
        .jtag_data_o   ( jtag_rdata  )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // stimulus helpers and reference model
    // ----------------------------------------------------------------------

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int nbits);
        logic [31:0] w;
        logic        fb;
        int          k;
        w = '0;
        for (k = 0; k < nbits; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            w = {w[30:0], lfsr_state[31]};
            lfsr_state = {lfsr_state[30:0], fb};
        end
        return w;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        if ((f3 == 3'd5) && alt) begin
            return $signed(a) >>> b[4:0];
        end
        case (f3)
            3'd0:    return alt ? (a - b) : (a + b);
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // op is funct3[1:0]: div, divu, rem, remu
    function automatic logic [31:0] div_ref(input logic [1:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic ovf;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff) && !op[0];
        if (b == 32'd0) begin
            if (op[1]) return a;
            return 32'hffff_ffff;
        end
        if (ovf) begin
            if (op[1]) return 32'd0;
            return a;
        end
        case (op)
            2'b00:   return $signed(a) / $signed(b);
            2'b01:   return a / b;
            2'b10:   return $signed(a) % $signed(b);
            default: return a % b;
        endcase
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic reg_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        jtag_we    <= 1'b1;
        jtag_addr  <= addr;
        jtag_wdata <= data;
        @(posedge clk);
        jtag_we <= 1'b0;
    endtask

    task automatic reg_read(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk);
        jtag_addr <= addr;
        @(negedge clk);
        data = jtag_rdata;
    endtask

    // returns right after the accepting edge
    task automatic issue_inst(input logic [31:0] word);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= word;
        @(posedge clk);
        inst_valid <= 1'b0;
    endtask

    task automatic wait_retire(input string what, input int limit, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire && (cycles < limit));
        if (!retire) begin
            stop_on_error($sformatf("timeout: %s did not retire within %0d cycles",
                                    what, limit));
        end
    endtask

    task automatic exec_op(input string name, input logic [31:0] word,
                           input logic [31:0] expected, input logic fixed_latency);
        int          cycles;
        logic [4:0]  rd;
        logic [31:0] rdata;
        rd = word[11:7];
        issue_inst(word);
        wait_retire(name, 80, cycles);
        if (fixed_latency) begin
            check_val($sformatf("%s latency", name), 32'd3, cycles);
        end
        check_val($sformatf("%s busy at retire", name), 32'd0, busy);
        check_val($sformatf("%s rd", name), rd, retire_rd);
        check_val($sformatf("%s data", name), expected, retire_data);
        reg_read(rd, rdata);
        check_val($sformatf("%s readback", name), (rd == 5'd0) ? 32'd0 : expected, rdata);
    endtask

    task automatic imm_op(input string name, input logic [2:0] f3, input logic [11:0] imm,
                          input logic [4:0] rs1, input logic [4:0] rd, input logic [31:0] a);
        exec_op(name, i_word(imm, rs1, f3, rd),
                alu_ref(f3, (f3 == 3'd5) && imm[10], a, {{20{imm[11]}}, imm}), 1'b1);
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic reset_values();
        logic [31:0] rdata;
        int          r;
        @(negedge clk);
        check_val("reset busy", 32'd0, busy);
        check_val("reset retire", 32'd0, retire);
        for (r = 0; r < 32; r++) begin
            reg_read(r[4:0], rdata);
            check_val($sformatf("reset x%0d", r), 32'd0, rdata);
        end
    endtask

    task automatic r_type_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        int          f;
        int          alt;
        a = lfsr_bits(32);
        b = lfsr_bits(32);
        reg_write(5'd1, a);
        reg_write(5'd2, b);
        rd = 5'd3;
        for (f = 0; f < 8; f++) begin
            for (alt = 0; alt < (((f == 0) || (f == 5)) ? 2 : 1); alt++) begin
                exec_op($sformatf("r-type f3=%0d alt=%0d", f, alt),
                        r_word((alt != 0) ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f[2:0], rd),
                        alu_ref(f[2:0], alt[0], a, b), 1'b1);
                rd++;
            end
        end
    endtask

    task automatic i_type_ops();
        logic [31:0] pos;
        logic [31:0] neg;
        pos = lfsr_bits(32) & 32'h7fff_ffff;
        neg = lfsr_bits(32) | 32'h8000_0000;
        reg_write(5'd13, pos);
        reg_write(5'd14, neg);
        imm_op("addi negative imm", 3'd0, 12'hffb, 5'd13, 5'd15, pos);
        imm_op("addi positive imm", 3'd0, 12'h123, 5'd14, 5'd16, neg);
        imm_op("slti minus one", 3'd2, 12'hfff, 5'd14, 5'd17, neg);
        imm_op("slti positive", 3'd2, 12'h7ff, 5'd13, 5'd18, pos);
        imm_op("sltiu minus one", 3'd3, 12'hfff, 5'd13, 5'd19, pos);
        imm_op("xori", 3'd4, 12'h8a5, 5'd13, 5'd20, pos);
        imm_op("ori", 3'd6, 12'h0f0, 5'd14, 5'd21, neg);
        imm_op("andi", 3'd7, 12'hf0f, 5'd14, 5'd22, neg);
        imm_op("slli", 3'd1, 12'h007, 5'd13, 5'd23, pos);
        imm_op("srli", 3'd5, 12'h00d, 5'd14, 5'd24, neg);
        imm_op("srai negative", 3'd5, 12'h409, 5'd14, 5'd15, neg);
        // destination x0 still retires its value
        imm_op("addi to x0", 3'd0, 12'h007, 5'd13, 5'd0, pos);
    endtask

    task automatic divide_ops();
        logic [31:0] dividend [5];
        logic [31:0] divisor [5];
        int          p;
        int          f;
        dividend[0] = lfsr_bits(32);
        divisor[0]  = lfsr_bits(16);
        dividend[1] = lfsr_bits(32) | 32'h8000_0000;
        divisor[1]  = lfsr_bits(12);
        dividend[2] = lfsr_bits(32) & 32'h7fff_ffff;
        divisor[2]  = -(lfsr_bits(8) + 32'd1);
        dividend[3] = lfsr_bits(32);
        divisor[3]  = 32'd0;
        dividend[4] = 32'h8000_0000;
        divisor[4]  = 32'hffff_ffff;
        for (p = 0; p < 5; p++) begin
            reg_write(5'd25, dividend[p]);
            reg_write(5'd26, divisor[p]);
            for (f = 4; f < 8; f++) begin
                exec_op($sformatf("divide case %0d f3=%0d", p, f),
                        r_word(7'b0000001, 5'd26, 5'd25, f[2:0], 5'd31),
                        div_ref(f[1:0], dividend[p], divisor[p]), 1'b0);
            end
        end
    endtask

    task automatic busy_blocks_issue();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] old;
        logic [31:0] rdata;
        int          cycles;
        int          extra;
        int          c;
        a   = lfsr_bits(32);
        b   = lfsr_bits(16) | 32'd1;
        old = lfsr_bits(32);
        reg_write(5'd25, a);
        reg_write(5'd26, b);
        reg_write(5'd20, old);
        issue_inst(r_word(7'b0000001, 5'd26, 5'd25, 3'd5, 5'd31));
        // second instruction arrives while the divider runs
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= r_word(7'b0000000, 5'd26, 5'd25, 3'd0, 5'd20);
        @(negedge clk);
        check_val("back-pressure busy", 32'd1, busy);
        @(posedge clk);
        inst_valid <= 1'b0;
        wait_retire("divide under back-pressure", 80, cycles);
        check_val("back-pressure rd", 32'd31, retire_rd);
        check_val("back-pressure data", div_ref(2'b01, a, b), retire_data);
        extra = 0;
        for (c = 0; c < 12; c++) begin
            @(negedge clk);
            if (retire) extra++;
        end
        check_val("back-pressure extra retires", 32'd0, extra);
        check_val("back-pressure busy after", 32'd0, busy);
        reg_read(5'd20, rdata);
        check_val("back-pressure x20 kept", old, rdata);
    endtask

    task automatic unsupported_word();
        int c;
        // lw x21, 4(x1)
        issue_inst({12'h004, 5'd1, 3'b010, 5'd21, 7'b0000011});
        for (c = 0; c < 12; c++) begin
            @(negedge clk);
            check_val("unsupported busy", 32'd0, busy);
            check_val("unsupported retire", 32'd0, retire);
        end
    endtask

    initial begin
        lfsr_state = 32'he664;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = 32'd0;
        jtag_we    = 1'b0;
        jtag_addr  = 5'd0;
        jtag_wdata = 32'd0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        r_type_ops();
        i_type_ops();
        divide_ops();
        busy_blocks_issue();
        unsupported_word();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/rooth_pkg.sv
rtl/ex_req_if.sv
rtl/issue_ctrl.sv
rtl/alu_unit.sv
rtl/div_unit.sv
rtl/wb_ctrl.sv
rtl/regs_file.sv
rtl/rooth_top.sv
verif/tb_rooth.sv
